// ==== Makefile ====
TOP := ioTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== displayDev.sv ====
`timescale 1ns/10ps

module displayDev import ioPkg::*; (
	input logic clk,
	input logic reset,
	ioBusIf.device bus,
	output word_t readWord,
	output seg_t hex0,
	output seg_t hex1,
	output seg_t hex2,
	output seg_t hex3,
	output seg_t hex4,
	output seg_t hex5,
	output logic [LedBits-1:0] ledr
);

	logic [HexBits-1:0] hexReg;
	logic [LedBits-1:0] ledReg;

	// Hex font, segments g down to a, low lights the segment
	function automatic seg_t segFont(input logic [3:0] nib);
		case (nib)
			4'h0: segFont = 7'b1000000;
			4'h1: segFont = 7'b1111001;
			4'h2: segFont = 7'b0100100;
			4'h3: segFont = 7'b0110000;
			4'h4: segFont = 7'b0011001;
			4'h5: segFont = 7'b0010010;
			4'h6: segFont = 7'b0000010;
			4'h7: segFont = 7'b1111000;
			4'h8: segFont = 7'b0000000;
			4'h9: segFont = 7'b0010000;
			4'hA: segFont = 7'b0001000;
			4'hB: segFont = 7'b0000011;
			4'hC: segFont = 7'b1000110;
			4'hD: segFont = 7'b0100001;
			4'hE: segFont = 7'b0000110;
			default: segFont = 7'b0001110;
		endcase
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hexReg <= HexReset;
			ledReg <= LedrReset;
		end else if (bus.wrEn) begin
			if (bus.regSel == selHex) begin
				hexReg <= bus.wrData[HexBits-1:0];
			end
			if (bus.regSel == selLedr) begin
				ledReg <= bus.wrData[LedBits-1:0];
			end
		end
	end

	// hex0 is the rightmost digit
	assign hex0 = segFont(hexReg[3:0]);
	assign hex1 = segFont(hexReg[7:4]);
	assign hex2 = segFont(hexReg[11:8]);
	assign hex3 = segFont(hexReg[15:12]);
	assign hex4 = segFont(hexReg[19:16]);
	assign hex5 = segFont(hexReg[23:20]);
	assign ledr = ledReg;

	always_comb begin
		case (bus.regSel)
			selHex: readWord = word_t'(hexReg);
			selLedr: readWord = word_t'(ledReg);
			default: readWord = '0;
		endcase
	end

endmodule

// ==== ioBusIf.sv ====
`timescale 1ns/10ps

interface ioBusIf import ioPkg::*; ();

	// Decoded access, valid in the same cycle as the raw strobes
	regSel_t regSel;
	logic wrEn;
	logic rdEn;
	word_t wrData;

	modport master (
		output regSel,
		output wrEn,
		output rdEn,
		output wrData
	);

	modport device (
		input regSel,
		input wrEn,
		input rdEn,
		input wrData
	);

endinterface

// ==== ioDecoder.sv ====
`timescale 1ns/10ps

module ioDecoder import ioPkg::*; (
	input word_t addr,
	input word_t wrData,
	input logic wrEn,
	input logic rdEn,
	ioBusIf.master bus,
	input word_t keyWord,
	input word_t timerWord,
	input word_t dispWord,
	output word_t rdData
);

	regSel_t regSel;

	// One address compare per register, shared by all devices
	always_comb begin
		case (addr)
			AddrHex: regSel = selHex;
			AddrLedr: regSel = selLedr;
			AddrKdata: regSel = selKdata;
			AddrKctrl: regSel = selKctrl;
			AddrTcnt: regSel = selTcnt;
			AddrTlim: regSel = selTlim;
			AddrTctl: regSel = selTctl;
			default: regSel = selNone;
		endcase
	end

	assign bus.regSel = regSel;
	assign bus.wrEn = wrEn;
	assign bus.rdEn = rdEn;
	assign bus.wrData = wrData;

	// Each device already zeroes its word when not selected
	always_comb begin
		case (regSel)
			selHex, selLedr: rdData = dispWord;
			selKdata, selKctrl: rdData = keyWord;
			selTcnt, selTlim, selTctl: rdData = timerWord;
			default: rdData = ReadUnmapped;
		endcase
	end

	// A bus master issues at most one kind of access per cycle
	always_comb begin
		strobeExclusive: assert final (!(wrEn && rdEn))
			else $error("write and read strobes high in the same cycle");
	end

endmodule

// ==== ioPkg.sv ====
package ioPkg;

	// Bus and device widths
	parameter int DataBits = 32;
	parameter int KeyBits = 4;
	parameter int HexBits = 24;
	parameter int LedBits = 10;

	typedef logic [DataBits-1:0] word_t;

	// Active low, bit 0 drives segment a
	typedef logic [6:0] seg_t;

	// Register map, one word per register
	parameter word_t AddrHex = 32'hFFFFF000;
	parameter word_t AddrLedr = 32'hFFFFF020;
	parameter word_t AddrKdata = 32'hFFFFF080;
	parameter word_t AddrKctrl = 32'hFFFFF084;
	parameter word_t AddrTcnt = 32'hFFFFF100;
	parameter word_t AddrTlim = 32'hFFFFF104;
	parameter word_t AddrTctl = 32'hFFFFF108;

	// Values seen right after reset
	parameter logic [HexBits-1:0] HexReset = 24'hFEDEAD;
	parameter logic [LedBits-1:0] LedrReset = 10'b1010101010;

	// Returned for any address outside the map
	parameter word_t ReadUnmapped = 32'hDEADDEAD;

	// Status bit positions in the key and timer control words
	parameter int StatRdy = 0;
	parameter int StatOvr = 1;

	typedef enum logic [2:0] {
		selNone,
		selHex,
		selLedr,
		selKdata,
		selKctrl,
		selTcnt,
		selTlim,
		selTctl
	} regSel_t;

endpackage

// ==== ioTb.sv ====
`timescale 1ns/10ps

module ioTb import ioPkg::*; ();

	localparam int TickClks = 5;
	localparam int RandCycles = 2000;
	// Reset plus directed and random cycles with slack
	localparam int TimeoutNs = (8 + 120 + RandCycles + 400) * 4;

	logic clk, reset, wrEn, rdEn;
	word_t addr, wrData, rdData;
	logic [KeyBits-1:0] key;
	seg_t hex0, hex1, hex2, hex3, hex4, hex5;
	logic [LedBits-1:0] ledr;

	// Reference model state at its reset values
	logic [KeyBits-1:0] kData = '0;
	logic [1:0] kStat = '0;
	logic [1:0] tStat = '0;
	word_t tCnt = '0;
	word_t tLim = '0;
	int preCnt = 0;
	logic [HexBits-1:0] hexShadow = HexReset;
	logic [LedBits-1:0] ledShadow = LedrReset;

	logic [15:0] lfsr = 16'd4210;
	string testName;
	logic [1:0] op;
	logic [2:0] idx;
	word_t randA, randD;
	logic [KeyBits-1:0] randK;

	// Active low digits 0 to F
	seg_t fontTab [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
	word_t mapAddr [7] = '{AddrHex, AddrLedr, AddrKdata, AddrKctrl, AddrTcnt, AddrTlim, AddrTctl};

	ioTop #(.ClksPerTick(TickClks)) ioTop_i (.*);

	always #2 clk = ~clk;

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic word_t randBits(input int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[DataBits-2:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic word_t expRead(input word_t at);
		case (at)
			AddrHex: return word_t'(hexShadow);
			AddrLedr: return word_t'(ledShadow);
			AddrKdata: return word_t'(kData);
			AddrKctrl: return word_t'(kStat);
			AddrTcnt: return tCnt;
			AddrTlim: return tLim;
			AddrTctl: return word_t'(tStat);
			default: return ReadUnmapped;
		endcase
	endfunction

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkWord(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			abortRun($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkSeg(input string name, input seg_t exp, input seg_t act);
		if (act !== exp)
			abortRun($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
	endtask

	task automatic checkLeds(input string name, input logic [LedBits-1:0] exp,
			input logic [LedBits-1:0] act);
		if (act !== exp)
			abortRun($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
	endtask

	// Advance the model by one rising edge using the inputs seen at that edge
	task automatic updateModel();
		logic [1:0] kNext;
		logic [1:0] tNext;
		word_t cntNext;
		kNext = kStat;
		if (rdEn && addr == AddrKdata)
			kNext = '0;
		else if (wrEn && addr == AddrKctrl && !wrData[StatOvr])
			kNext[StatOvr] = 1'b0;
		if (~key != kData) begin
			kNext[StatRdy] = 1'b1;
			kNext[StatOvr] = kStat[StatRdy];
		end
		kData = ~key;
		kStat = kNext;
		tNext = tStat;
		cntNext = tCnt;
		if (wrEn && addr == AddrTcnt)
			cntNext = '0;
		if (wrEn && addr == AddrTctl)
			tNext = tStat & wrData[1:0];
		if (rdEn && addr == AddrTcnt)
			tNext = '0;
		if (preCnt == TickClks - 1) begin
			preCnt = 0;
			if (tLim != '0 && tCnt == tLim - 1) begin
				cntNext = '0;
				tNext[StatRdy] = 1'b1;
				tNext[StatOvr] = tStat[StatRdy];
			end else begin
				cntNext = tCnt + 1;
			end
		end else begin
			preCnt++;
		end
		if (wrEn && addr == AddrTlim)
			tLim = wrData;
		tCnt = cntNext;
		tStat = tNext;
		if (wrEn && addr == AddrHex)
			hexShadow = wrData[HexBits-1:0];
		if (wrEn && addr == AddrLedr)
			ledShadow = wrData[LedBits-1:0];
	endtask

	// One bus cycle with all outputs checked mid-cycle against the model
	task automatic stepCycle(input word_t at, input word_t dat, input logic wr, input logic rd,
			input logic [KeyBits-1:0] k);
		@(posedge clk);
		updateModel();
		addr <= at;
		wrData <= dat;
		wrEn <= wr;
		rdEn <= rd;
		key <= k;
		@(negedge clk);
		checkWord(testName, expRead(addr), rdData);
		checkSeg({testName, " hex0"}, fontTab[hexShadow[3:0]], hex0);
		checkSeg({testName, " hex1"}, fontTab[hexShadow[7:4]], hex1);
		checkSeg({testName, " hex2"}, fontTab[hexShadow[11:8]], hex2);
		checkSeg({testName, " hex3"}, fontTab[hexShadow[15:12]], hex3);
		checkSeg({testName, " hex4"}, fontTab[hexShadow[19:16]], hex4);
		checkSeg({testName, " hex5"}, fontTab[hexShadow[23:20]], hex5);
		checkLeds({testName, " ledr"}, ledShadow, ledr);
	endtask

	task automatic readCheck(input word_t at, input word_t exp);
		stepCycle(at, '0, 1'b0, 1'b1, key);
		checkWord({testName, " readback"}, exp, rdData);
	endtask

	initial begin
		#(TimeoutNs);
		$display("Timeout after %0d ns, the run never reached its end", TimeoutNs);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		addr = '0;
		wrData = '0;
		wrEn = 1'b0;
		rdEn = 1'b0;
		key = '1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// Timer registers first while no tick has happened yet
		testName = "after reset";
		readCheck(AddrTcnt, '0);
		readCheck(AddrTlim, '0);
		readCheck(AddrTctl, '0);
		readCheck(AddrKdata, '0);
		readCheck(AddrKctrl, '0);
		readCheck(AddrHex, 32'h00FEDEAD);
		readCheck(AddrLedr, 32'h000002AA);
		readCheck(32'h00000010, 32'hDEADDEAD);

		testName = "display write";
		stepCycle(AddrHex, 32'hA5123456, 1'b1, 1'b0, key);
		stepCycle(AddrLedr, 32'hFFFFF3C5, 1'b1, 1'b0, key);
		readCheck(AddrHex, 32'h00123456);
		readCheck(AddrLedr, 32'h000003C5);

		testName = "key status";
		stepCycle(AddrKctrl, '0, 1'b0, 1'b0, 4'b1110);
		readCheck(AddrKctrl, 32'h1);
		stepCycle(AddrKctrl, '0, 1'b0, 1'b0, 4'b1100);
		readCheck(AddrKctrl, 32'h3);
		readCheck(AddrKdata, 32'h3);
		readCheck(AddrKctrl, 32'h0);

		testName = "key overrun clear";
		stepCycle(AddrKctrl, '0, 1'b0, 1'b0, 4'b0111);
		stepCycle(AddrKctrl, '0, 1'b0, 1'b0, 4'b1111);
		readCheck(AddrKctrl, 32'h3);
		stepCycle(AddrKctrl, 32'h1, 1'b1, 1'b0, key);
		readCheck(AddrKctrl, 32'h1);

		testName = "timer limit";
		stepCycle(AddrTlim, 32'd3, 1'b1, 1'b0, key);
		stepCycle(AddrTcnt, '0, 1'b1, 1'b0, key);
		repeat (40) stepCycle(AddrTcnt, '0, 1'b0, 1'b0, key);
		readCheck(AddrTctl, 32'h3);
		stepCycle(AddrTctl, 32'h1, 1'b1, 1'b0, key);
		readCheck(AddrTctl, 32'h1);
		// A wrap on the next edge sets both bits again before the count read clears them
		stepCycle(AddrTctl, '0, 1'b0, 1'b0, key);
		readCheck(AddrTcnt, 32'h0);
		readCheck(AddrTctl, 32'h0);

		testName = "random";
		repeat (RandCycles) begin
			op = 2'(randBits(2));
			idx = 3'(randBits(3));
			case (op)
				2'd0: stepCycle(addr, wrData, 1'b0, 1'b0, key);
				2'd1: begin
					randA = mapAddr[idx % 3'd7];
					randD = randBits(DataBits);
					// Small limits so the timer actually wraps
					if (randA == AddrTlim)
						randD = randD & 32'hF;
					stepCycle(randA, randD, 1'b1, 1'b0, key);
				end
				2'd2: begin
					randA = (idx == 3'd7) ? word_t'(randBits(12)) : mapAddr[idx];
					stepCycle(randA, '0, 1'b0, 1'b1, key);
				end
				default: begin
					randK = KeyBits'(randBits(KeyBits));
					stepCycle(addr, wrData, 1'b0, 1'b0, randK);
				end
			endcase
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== ioTop.sv ====
`timescale 1ns/10ps

module ioTop import ioPkg::*; #(
	parameter int ClksPerTick = 100000
) (
	input logic clk,
	input logic reset,
	input word_t addr,
	input word_t wrData,
	input logic wrEn,
	input logic rdEn,
	output word_t rdData,
	input logic [KeyBits-1:0] key,
	output seg_t hex0,
	output seg_t hex1,
	output seg_t hex2,
	output seg_t hex3,
	output seg_t hex4,
	output seg_t hex5,
	output logic [LedBits-1:0] ledr
);

	ioBusIf bus ();

	// Read words returned by each device
	word_t keyWord;
	word_t timerWord;
	word_t dispWord;

	ioDecoder ioDecoder_i (
		.addr(addr),
		.wrData(wrData),
		.wrEn(wrEn),
		.rdEn(rdEn),
		.bus(bus.master),
		.keyWord(keyWord),
		.timerWord(timerWord),
		.dispWord(dispWord),
		.rdData(rdData)
	);

	keyDev keyDev_i (
		.clk(clk),
		.reset(reset),
		.key(key),
		.bus(bus.device),
		.readWord(keyWord)
	);

	timerDev #(
		.ClksPerTick(ClksPerTick)
	) timerDev_i (
		.clk(clk),
		.reset(reset),
		.bus(bus.device),
		.readWord(timerWord)
	);

	displayDev displayDev_i (
		.clk(clk),
		.reset(reset),
		.bus(bus.device),
		.readWord(dispWord),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.ledr(ledr)
	);

endmodule

// ==== keyDev.sv ====
`timescale 1ns/10ps

module keyDev import ioPkg::*; (
	input logic clk,
	input logic reset,
	input logic [KeyBits-1:0] key,
	ioBusIf.device bus,
	output word_t readWord
);

	// Keys are active low, kdata holds them as pressed = 1
	logic [KeyBits-1:0] kdata;
	logic [1:0] stat;
	logic keyChange;

	assign keyChange = (~key != kdata);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			kdata <= '0;
			stat <= '0;
		end else begin
			kdata <= ~key;
			if (bus.rdEn && bus.regSel == selKdata) begin
				stat <= '0;
			end else if (bus.wrEn && bus.regSel == selKctrl && !bus.wrData[StatOvr]) begin
				stat[StatOvr] <= 1'b0;
			end
			// A new key event overrides either clear
			if (keyChange) begin
				stat[StatRdy] <= 1'b1;
				stat[StatOvr] <= stat[StatRdy];
			end
		end
	end

	always_comb begin
		case (bus.regSel)
			selKdata: readWord = word_t'(kdata);
			selKctrl: readWord = word_t'(stat);
			default: readWord = '0;
		endcase
	end

	overrunNeedsReady: assert property (
		@(posedge clk) disable iff (reset) stat[StatOvr] |-> stat[StatRdy]
	) else $error("key overrun set without key ready");

endmodule

// ==== project.f ====
ioPkg.sv
ioBusIf.sv
ioDecoder.sv
keyDev.sv
timerDev.sv
displayDev.sv
ioTop.sv
ioTb.sv

// ==== timerDev.sv ====
`timescale 1ns/10ps

module timerDev import ioPkg::*; #(
	parameter int ClksPerTick = 100000
) (
	input logic clk,
	input logic reset,
	ioBusIf.device bus,
	output word_t readWord
);

	localparam int PreBits = (ClksPerTick > 1) ? $clog2(ClksPerTick) : 1;

	logic [PreBits-1:0] preCnt;
	logic tick;
	word_t tcnt;
	word_t tlim;
	logic [1:0] stat;

	// Prescaler wraps once per millisecond
	assign tick = (preCnt == PreBits'(ClksPerTick - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			preCnt <= '0;
			tcnt <= '0;
			tlim <= '0;
			stat <= '0;
		end else begin
			if (bus.wrEn) begin
				case (bus.regSel)
					selTcnt: tcnt <= '0;
					selTlim: tlim <= bus.wrData;
					selTctl: begin
						// Bits written as zero clear, ones leave the bit alone
						stat[StatRdy] <= stat[StatRdy] & bus.wrData[StatRdy];
						stat[StatOvr] <= stat[StatOvr] & bus.wrData[StatOvr];
					end
					default: ;
				endcase
			end
			if (bus.rdEn && bus.regSel == selTcnt) begin
				stat <= '0;
			end

			// Later assignments win, so the wrap beats any access above
			if (tick) begin
				preCnt <= '0;
				if (tlim != '0 && tcnt == tlim - word_t'(1)) begin
					tcnt <= '0;
					stat[StatRdy] <= 1'b1;
					stat[StatOvr] <= stat[StatRdy];
				end else begin
					tcnt <= tcnt + word_t'(1);
				end
			end else begin
				preCnt <= preCnt + 1'b1;
			end
		end
	end

	always_comb begin
		case (bus.regSel)
			selTcnt: readWord = tcnt;
			selTlim: readWord = tlim;
			selTctl: readWord = word_t'(stat);
			default: readWord = '0;
		endcase
	end

	prescalerInRange: assert property (
		@(posedge clk) disable iff (reset) preCnt < ClksPerTick
	) else $error("timer prescaler ran past its wrap point");

endmodule
